//--- source/spi_pkg.sv
// SPI byte memory package with sizes, sequencer states and stage bundles

package spi_pkg;

    // ########################################
    // Sizes
    // ########################################

    localparam int addr_w    = 7;    // Command byte carries a 7-bit address
    localparam int data_w    = 8;
    localparam int mem_depth = 128;  // One entry per address
    localparam int bit_cnt_w = 4;    // Counts up to 8 bits

    // ########################################
    // Sequencer states
    // ########################################

    typedef enum logic [2:0] {
        st_get    = 3'd0,  // Shifting in the command byte
        st_got    = 3'd1,  // Decoding the command
        st_read1  = 3'd2,  // Memory read cycle
        st_read2  = 3'd3,  // Load read byte into the shift register
        st_read3  = 3'd4,  // Shifting out 8 bits
        st_write1 = 3'd5,  // Shifting in 8 data bits
        st_write2 = 3'd6,  // Memory write pulse
        st_done   = 3'd7   // Waiting for cs to rise
    } ctrl_state_e;

    // ########################################
    // Stage bundles
    // ########################################

    // One clkedge cycle of synchronized pin state
    typedef struct packed {
        logic mosi;
        logic cs_active;
        logic sclk_rise;
        logic sclk_fall;
    } spi_sample_t;

    // Strobes from the sequencer
    typedef struct packed {
        logic addr_we;  // Latch the address
        logic dm_we;    // Write memory
        logic sr_load;  // Load the shift register
    } mem_ctrl_t;

endpackage

//--- source/spi_input_sync.sv
// SPI pin synchronizer with sclk edge detection into the clkedge domain

`timescale 1ns/1ps

module spi_input_sync (
    input  logic                 clkedge,
    input  logic                 rst,
    input  logic                 sclk,
    input  logic                 cs,
    input  logic                 mosi,
    output spi_pkg::spi_sample_t sample
);

    logic [1:0] sclk_ff;
    logic [1:0] cs_ff;
    logic [1:0] mosi_ff;
    logic       sclk_d;     // Previous synchronized sclk
    logic       sel;        // Device selected, synchronized

    assign sel = ~cs_ff[1];

    // ########################################
    // Two-flop synchronizers
    // ########################################

    always_ff @(posedge clkedge) begin
        if (rst) begin
            sclk_ff <= 2'b00;
            cs_ff   <= 2'b11;  // Deselected
            mosi_ff <= 2'b00;
        end else begin
            sclk_ff <= {sclk_ff[0], sclk};
            cs_ff   <= {cs_ff[0], cs};
            mosi_ff <= {mosi_ff[0], mosi};
        end
    end

    // ########################################
    // Edge register
    // ########################################

    always_ff @(posedge clkedge) begin
        if (rst) begin
            sclk_d <= 1'b0;
            sample <= '0;
        end else begin
            sclk_d           <= sclk_ff[1];
            sample.mosi      <= mosi_ff[1];
            sample.cs_active <= sel;
            sample.sclk_rise <= sclk_ff[1] & ~sclk_d & sel;  // One cycle wide
            sample.sclk_fall <= ~sclk_ff[1] & sclk_d & sel;
        end
    end

endmodule

//--- source/spi_shift_reg.sv
// SPI shift register with serial in on sclk rise and serial out on sclk fall

`timescale 1ns/1ps

module spi_shift_reg (
    input  logic                          clkedge,
    input  logic                          rst,
    input  spi_pkg::spi_sample_t          sample,
    input  spi_pkg::mem_ctrl_t            ctrl,
    input  logic [spi_pkg::data_w-1:0]    rd_data,
    output logic [spi_pkg::data_w-1:0]    shift_data,
    output logic                          miso
);

    logic [spi_pkg::data_w-1:0] sr;

    assign shift_data = sr;

    // ########################################
    // Shift and load
    // ########################################

    always_ff @(posedge clkedge) begin
        if (ctrl.sr_load) begin
            sr <= rd_data;                                    // Load wins over shift
        end else if (sample.sclk_rise) begin
            sr <= {sr[spi_pkg::data_w-2:0], sample.mosi};     // Shift left, mosi into LSB
        end
    end

    // ########################################
    // Output pin
    // ########################################

    // The MSB goes out on the fall so it is stable before the master's next rise.
    // The following rise shifts the next bit up into the MSB.
    always_ff @(posedge clkedge) begin
        if (rst) begin
            miso <= 1'b0;
        end else if (sample.sclk_fall) begin
            miso <= sr[spi_pkg::data_w-1];
        end
    end

endmodule

//--- source/spi_ctrl_fsm.sv
// SPI transaction sequencer that counts bits, decodes the command and times the strobes

`timescale 1ns/1ps

module spi_ctrl_fsm (
    input  logic                 clkedge,
    input  logic                 rst,
    input  spi_pkg::spi_sample_t sample,
    input  logic                 rw_bit,   // 1 means read
    output spi_pkg::mem_ctrl_t   ctrl,
    output logic                 miso_oe
);

    spi_pkg::ctrl_state_e           state;
    logic [spi_pkg::bit_cnt_w-1:0]  bit_cnt;
    logic [spi_pkg::bit_cnt_w-1:0]  cnt_inc;
    logic                           byte_end;   // This pulse completes a byte
    logic                           byte_sent;  // All bits of the read byte shown

    assign cnt_inc   = bit_cnt + 1'b1;
    assign byte_end  = (cnt_inc == spi_pkg::bit_cnt_w'(spi_pkg::data_w));
    assign byte_sent = (bit_cnt == spi_pkg::bit_cnt_w'(spi_pkg::data_w));

    // ########################################
    // Sequencer
    // ########################################

    always_ff @(posedge clkedge) begin
        if (rst) begin
            state   <= spi_pkg::st_get;
            bit_cnt <= '0;
            ctrl    <= '0;
            miso_oe <= 1'b0;
        end else begin
            ctrl <= '0;                               // Strobes are single pulses

            if (!sample.cs_active) begin
                state   <= spi_pkg::st_get;           // cs release aborts anything
                bit_cnt <= '0;
                miso_oe <= 1'b0;
            end else begin
                case (state)
                    spi_pkg::st_get: begin
                        if (sample.sclk_rise) begin
                            if (byte_end) begin
                                bit_cnt      <= '0;
                                state        <= spi_pkg::st_got;
                                ctrl.addr_we <= 1'b1;  // Active during st_got
                            end else begin
                                bit_cnt <= cnt_inc;
                            end
                        end
                    end

                    spi_pkg::st_got: begin
                        state <= rw_bit ? spi_pkg::st_read1 : spi_pkg::st_write1;
                    end

                    spi_pkg::st_read1: begin
                        state        <= spi_pkg::st_read2;  // Memory reads here
                        ctrl.sr_load <= 1'b1;
                    end

                    spi_pkg::st_read2: begin
                        state   <= spi_pkg::st_read3;
                        miso_oe <= 1'b1;
                    end

                    // Eight falls shift the byte out and the next one ends the last bit
                    spi_pkg::st_read3: begin
                        if (sample.sclk_fall) begin
                            if (byte_sent) begin
                                bit_cnt <= '0;
                                state   <= spi_pkg::st_done;
                                miso_oe <= 1'b0;
                            end else begin
                                bit_cnt <= cnt_inc;
                            end
                        end
                    end

                    spi_pkg::st_write1: begin
                        if (sample.sclk_rise) begin
                            if (byte_end) begin
                                bit_cnt    <= '0;
                                state      <= spi_pkg::st_write2;
                                ctrl.dm_we <= 1'b1;    // Active during st_write2
                            end else begin
                                bit_cnt <= cnt_inc;
                            end
                        end
                    end

                    spi_pkg::st_write2: begin
                        state <= spi_pkg::st_done;
                    end

                    spi_pkg::st_done: begin
                        bit_cnt <= '0;                 // Hold until cs rises
                    end
                endcase
            end
        end
    end

endmodule

//--- source/spi_data_mem.sv
// SPI memory store with address latch and a 128 by 8 synchronous array

`timescale 1ns/1ps

module spi_data_mem (
    input  logic                       clkedge,
    input  logic                       rst,
    input  spi_pkg::mem_ctrl_t         ctrl,
    input  logic [spi_pkg::data_w-1:0] shift_data,
    output logic [spi_pkg::data_w-1:0] rd_data
);

    logic [spi_pkg::data_w-1:0] mem [spi_pkg::mem_depth];
    logic [spi_pkg::addr_w-1:0] addr;

    // Address is the upper bits of the command byte
    always_ff @(posedge clkedge) begin
        if (rst) begin
            addr <= '0;
        end else if (ctrl.addr_we) begin
            addr <= shift_data[spi_pkg::data_w-1:spi_pkg::data_w-spi_pkg::addr_w];
        end
    end

    always_ff @(posedge clkedge) begin
        if (ctrl.dm_we) begin
            mem[addr] <= shift_data;
        end
    end

    // One cycle read latency
    always_ff @(posedge clkedge) begin
        if (rst) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[addr];
        end
    end

endmodule

//--- source/spi_memory.sv
// SPI-attached byte memory top level joining sync, shift, sequencer and store

`timescale 1ns/1ps

module spi_memory (
    input  logic clkedge,
    input  logic rst,
    input  logic sclk,
    input  logic cs,       // Active low
    input  logic mosi,
    output logic miso,
    output logic miso_oe
);

    spi_pkg::spi_sample_t       sample;
    spi_pkg::mem_ctrl_t         ctrl;
    logic [spi_pkg::data_w-1:0] shift_data;
    logic [spi_pkg::data_w-1:0] rd_data;

    // ########################################
    // Stages
    // ########################################

    spi_input_sync u_sync (
        .clkedge (clkedge),
        .rst     (rst),
        .sclk    (sclk),
        .cs      (cs),
        .mosi    (mosi),
        .sample  (sample)
    );

    spi_shift_reg u_shift (
        .clkedge    (clkedge),
        .rst        (rst),
        .sample     (sample),
        .ctrl       (ctrl),
        .rd_data    (rd_data),
        .shift_data (shift_data),
        .miso       (miso)
    );

    spi_ctrl_fsm u_fsm (
        .clkedge (clkedge),
        .rst     (rst),
        .sample  (sample),
        .rw_bit  (shift_data[0]),   // Last command bit
        .ctrl    (ctrl),
        .miso_oe (miso_oe)
    );

    spi_data_mem u_mem (
        .clkedge    (clkedge),
        .rst        (rst),
        .ctrl       (ctrl),
        .shift_data (shift_data),
        .rd_data    (rd_data)
    );

endmodule

//--- test/spi_memory_tb.sv
// Testbench for the SPI byte memory with a bit-banged master and a reference model

`timescale 1ns/1ps

module spi_memory_tb;

    typedef enum logic [1:0] {
        op_write,
        op_read,
        op_abort   // Write cut short by cs after nbits
    } op_e;

    typedef struct packed {
        op_e        op;
        int         nbits;
        logic [6:0] addr;
        logic [7:0] data;
    } test_entry_t;

    logic clkedge;
    logic rst;
    logic sclk;
    logic cs;
    logic mosi;
    logic miso;
    logic miso_oe;

    test_entry_t tab[$];
    string       tab_name[$];
    logic [7:0]  ref_mem [spi_pkg::mem_depth];
    int          err_cnt = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    logic [31:0] lcg_state = 32'he822_bd4e;

    spi_memory u_dut (
        .clkedge (clkedge),
        .rst     (rst),
        .sclk    (sclk),
        .cs      (cs),
        .mosi    (mosi),
        .miso    (miso),
        .miso_oe (miso_oe)
    );

    initial begin
        clkedge = 1'b0;
        forever #4 clkedge = ~clkedge;   // 8 ns period
    end

    always @(posedge clkedge) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the SPI transactions did not finish within %0d cycles",
                     cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // ########################################
    // Helpers
    // ########################################

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge clkedge);
        #1;                               // Drive just after the edge
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %02h actual %02h", name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic add_entry(input string name, input op_e op, input logic [6:0] addr,
                             input logic [7:0] data, input int nbits);
        test_entry_t e;
        e.op    = op;
        e.nbits = nbits;
        e.addr  = addr;
        e.data  = data;
        tab.push_back(e);
        tab_name.push_back(name);
    endtask

    // Mode 0 master, one command byte then one data byte
    task automatic spi_transfer(input string name, input logic [7:0] cmd,
                                input logic [7:0] wdata, input int nbits,
                                input logic is_read, output logic [7:0] rdata);
        logic [15:0] frame;
        logic        oe_exp;
        frame = {cmd, wdata};
        rdata = 8'h00;
        cs    = 1'b0;
        step(4);
        for (int i = 0; i < nbits; i++) begin
            mosi   = frame[15];                 // Set while sclk is low
            frame  = frame << 1;
            oe_exp = is_read && (i >= 8);
            step(4);
            check_value({name, " miso_oe"}, {7'd0, oe_exp}, {7'd0, miso_oe});
            if (oe_exp) begin
                rdata = {rdata[6:0], miso};     // Sample just before the rise
            end
            sclk = 1'b1;
            step(4);
            sclk = 1'b0;
        end
        mosi = 1'b0;
        step(4);
        cs = 1'b1;
        step(8);
        check_value({name, " idle miso_oe"}, 8'h00, {7'd0, miso_oe});
    endtask

    // ########################################
    // Test table
    // ########################################

    task automatic build_table();
        logic [6:0] ra;
        logic [7:0] rd;
        add_entry("wr_basic",   op_write, 7'd5,   8'ha5, 16);
        add_entry("rd_basic",   op_read,  7'd5,   8'h00, 16);
        add_entry("wr_addr0",   op_write, 7'd0,   8'h11, 16);
        add_entry("wr_addr1",   op_write, 7'd1,   8'h22, 16);
        add_entry("wr_addr63",  op_write, 7'd63,  8'h3c, 16);
        add_entry("wr_addr127", op_write, 7'd127, 8'h7f, 16);
        add_entry("rd_addr127", op_read,  7'd127, 8'h00, 16);
        add_entry("rd_addr0",   op_read,  7'd0,   8'h00, 16);
        add_entry("rd_addr63",  op_read,  7'd63,  8'h00, 16);
        add_entry("rd_addr1",   op_read,  7'd1,   8'h00, 16);
        add_entry("wr_abort12", op_abort, 7'd1,   8'hee, 12);
        add_entry("rd_aborted", op_read,  7'd1,   8'h00, 16);
        add_entry("wr_after",   op_write, 7'd2,   8'h5a, 16);
        add_entry("rd_after",   op_read,  7'd2,   8'h00, 16);
        add_entry("wr_first",   op_write, 7'd9,   8'hc3, 16);
        add_entry("wr_over",    op_write, 7'd9,   8'h3e, 16);
        add_entry("rd_over",    op_read,  7'd9,   8'h00, 16);
        for (int k = 0; k < 20; k++) begin
            lcg_state = lcg_next(lcg_state);
            ra = lcg_state[30:24];
            rd = lcg_state[15:8];
            add_entry($sformatf("rand_wr_%0d", k), op_write, ra, rd, 16);
            add_entry($sformatf("rand_rd_%0d", k), op_read, ra, 8'h00, 16);
        end
    endtask

    task automatic run_entry(input int idx);
        test_entry_t e;
        string       name;
        logic [7:0]  rdata;
        int          err_before;
        e          = tab[idx];
        name       = tab_name[idx];
        err_before = err_cnt;
        case (e.op)
            op_write: begin
                spi_transfer(name, {e.addr, 1'b0}, e.data, 16, 1'b0, rdata);
                ref_mem[e.addr] = e.data;       // Completed write updates the model
            end
            op_read: begin
                spi_transfer(name, {e.addr, 1'b1}, 8'h00, 16, 1'b1, rdata);
                check_value(name, ref_mem[e.addr], rdata);
            end
            op_abort: begin
                spi_transfer(name, {e.addr, 1'b0}, e.data, e.nbits, 1'b0, rdata);
            end
            default: begin
                $display("%s has an unknown operation in the table", name);
                err_cnt++;
            end
        endcase
        if (err_cnt == err_before) begin
            tests_ok++;
            $display("%-14s ok", name);
        end else begin
            tests_bad++;
            $display("%-14s FAILED", name);
        end
    endtask

    // ########################################
    // Main sequence
    // ########################################

    initial begin
        rst  = 1'b1;
        sclk = 1'b0;
        cs   = 1'b1;
        mosi = 1'b0;
        build_table();
        cycle_limit = tab.size() * 200 + 200;
        repeat (5) @(posedge clkedge);
        #1;
        rst = 1'b0;
        step(2);
        check_value("reset miso_oe", 8'h00, {7'd0, miso_oe});
        check_value("reset miso", 8'h00, {7'd0, miso});
        for (int i = 0; i < tab.size(); i++) begin
            run_entry(i);
        end
        $display("Summary: %0d ok, %0d failing, %0d mismatches", tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
source/spi_pkg.sv
source/spi_input_sync.sv
source/spi_shift_reg.sv
source/spi_ctrl_fsm.sv
source/spi_data_mem.sv
source/spi_memory.sv
test/spi_memory_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module spi_memory_tb \
    -f files.f \
    -o sim_spi_memory \
    && ./obj_dir/sim_spi_memory | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "All tests passed" sim.log \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }
